// ==== Makefile ====
# Verilator build and run for the loopback tester testbench
TOP = tb_nlb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f

# Pass only when the pass message shows up in the simulation output
run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// ==== verif/nlb_mem_model.sv ====
// ---------------------------------------------------------------------------
// Testbench line memory with credits. Lines 0 to PRELOAD_LINES-1 start
// with LFSR data, other unwritten lines read as the address repeated.
// Credit returns and read responses come back after random delays.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module nlb_mem_model (
   input  logic              Clk_100,
   input  logic              reset,
   input  nlb_pkg::mem_req_t mem_req,
   output logic              credit_return,
   output nlb_pkg::mem_rsp_t mem_rsp
);

   import nlb_pkg::*;

   localparam int          PRELOAD_LINES = 1024;
   localparam logic [31:0] SEED          = 32'h9887_89b6;

   // Sparse line store, indexed by line address
   logic [LINE_W-1:0] mem [logic [ADDR_W-1:0]];
   logic [31:0]       lfsr;
   int                credits_owed;
   int                credit_wait;
   int                num_requests;

   // Reads waiting for their delay to run out
   int                rsp_wait [$];
   logic [ADDR_W-1:0] rsp_tag  [$];
   logic [LINE_W-1:0] rsp_data [$];

   // Galois step, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   // One LFSR step per bit taken
   function automatic int take_bits(input int n);
      int r;
      r = 0;
      for (int i = 0; i < n; i++) begin
         r    = (r << 1) | int'(lfsr[0]);
         lfsr = lfsr_step(lfsr);
      end
      return r;
   endfunction

   initial begin
      logic [ADDR_W-1:0] a;
      logic [31:0]       hi;
      logic [31:0]       lo;
      credit_return <= 1'b0;
      mem_rsp       <= '0;
      lfsr = SEED;
      for (int i = 0; i < PRELOAD_LINES; i++) begin
         a  = ADDR_W'(i);
         hi = 32'(take_bits(32));
         lo = 32'(take_bits(32));
         // Address folded in so no two lines match
         mem[a] = {hi, lo} ^ {4{a}};
      end
   end

   always @(posedge Clk_100) begin
      int pick;
      if (reset) begin
         // First credits go out right after reset
         credits_owed = MEM_CREDITS;
         credit_wait  = 0;
         num_requests = 0;
         rsp_wait.delete();
         rsp_tag.delete();
         rsp_data.delete();
         credit_return <= 1'b0;
         mem_rsp       <= '0;
      end else begin
         if (mem_req.valid) begin
            num_requests = num_requests + 1;
            credits_owed = credits_owed + 1;
            $display("Mem request %0d, %s addr %h tag %h", num_requests,
                     mem_req.write ? "wr" : "rd", mem_req.addr, mem_req.tag);
            if (mem_req.write) begin
               mem[mem_req.addr] = mem_req.data;
            end else begin
               rsp_wait.push_back(take_bits(3));
               rsp_tag.push_back(mem_req.tag);
               rsp_data.push_back(mem.exists(mem_req.addr) ? mem[mem_req.addr]
                                                           : {4{mem_req.addr}});
            end
         end
         // At most one credit pulse per cycle, random gaps
         credit_return <= 1'b0;
         if (credit_wait > 0) begin
            credit_wait = credit_wait - 1;
         end else if (credits_owed > 0) begin
            credit_return <= 1'b1;
            credits_owed = credits_owed - 1;
            credit_wait  = take_bits(2);
         end
         // Oldest expired entry answers, the rest keep aging
         mem_rsp <= '0;
         pick = -1;
         for (int i = 0; i < rsp_wait.size(); i++) begin
            if (rsp_wait[i] == 0 && pick < 0) pick = i;
            else if (rsp_wait[i] > 0) rsp_wait[i] = rsp_wait[i] - 1;
         end
         if (pick >= 0) begin
            mem_rsp <= '{valid: 1'b1, tag: rsp_tag[pick], data: rsp_data[pick]};
            rsp_wait.delete(pick);
            rsp_tag.delete(pick);
            rsp_data.delete(pick);
         end
      end
   end

endmodule

`default_nettype wire

// ==== verif/tb_nlb.sv ====
// ---------------------------------------------------------------------------
// Testbench for the loopback tester. Register test first, then a fixed
// table of mode runs. Source regions must sit in the model's preload
// window, destination regions must not overlap any source.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_nlb;

   import nlb_pkg::*;

   localparam int CLK_PERIOD      = 10;
   localparam int NUM_TESTS       = 5;
   localparam int CYCLES_PER_LINE = 50;
   localparam int CYCLES_PER_TEST = 300;

   typedef struct packed {
      test_mode_e         mode;
      logic [ADDR_W-1:0]  src;
      logic [ADDR_W-1:0]  dst;
      logic [COUNT_W-1:0] lines;
   } test_t;

   typedef struct packed {
      logic [COUNT_W-1:0] reads;
      logic [COUNT_W-1:0] writes;
      logic [LINE_W-1:0]  line;
   } expect_t;

   logic      Clk_100 = 1'b0;
   logic      reset;
   mmio_req_t mmio_req;
   mmio_rsp_t mmio_rsp;
   mem_req_t  mem_req;
   mem_rsp_t  mem_rsp;
   logic      credit_return;

   // Bus monitor state
   int                granted;
   int                consumed;
   int                rd_hits  [int];
   int                wr_hits  [int];
   logic [LINE_W-1:0] wr_lines [int];

   always #(CLK_PERIOD / 2) Clk_100 = ~Clk_100;

   nlb_top dut_i (
      .Clk_100       (Clk_100),
      .reset         (reset),
      .mmio_req      (mmio_req),
      .mmio_rsp      (mmio_rsp),
      .mem_req       (mem_req),
      .credit_return (credit_return),
      .mem_rsp       (mem_rsp)
   );

   nlb_mem_model mem_model_i (
      .Clk_100       (Clk_100),
      .reset         (reset),
      .mem_req       (mem_req),
      .credit_return (credit_return),
      .mem_rsp       (mem_rsp)
   );

   // -------------------------------------------------------------------------
   // Test table and expected results
   // -------------------------------------------------------------------------
   function automatic test_t test_entry(input int k);
      case (k)
         0:       return '{mode: M_READ,  src: 16'h0100, dst: 16'h0000, lines: 32'd20};
         1:       return '{mode: M_WRITE, src: 16'h0000, dst: 16'h2000, lines: 32'd17};
         2:       return '{mode: M_TRPUT, src: 16'h0140, dst: 16'h3000, lines: 32'd25};
         3:       return '{mode: M_LPBK1, src: 16'h0180, dst: 16'h4000, lines: 32'd30};
         // Restart with a shorter run
         default: return '{mode: M_LPBK1, src: 16'h0200, dst: 16'h5000, lines: 32'd9};
      endcase
   endfunction

   // Counters per mode, and the line expected at dst + idx
   function automatic expect_t expected_result(input test_mode_e mode, input int n,
                                               input int idx, input logic [63:0] src_line);
      expect_t e;
      e.reads  = (mode == M_WRITE) ? 32'd0 : 32'(n);
      e.writes = (mode == M_READ) ? 32'd0 : 32'(n);
      e.line   = (mode == M_LPBK1) ? src_line : {WR_PATTERN, 32'(idx)};
      return e;
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   // -------------------------------------------------------------------------
   // MMIO access
   // -------------------------------------------------------------------------
   task automatic mmio_write(input csr_addr_e a, input logic [63:0] d);
      @(posedge Clk_100);
      mmio_req <= '{valid: 1'b1, write: 1'b1, addr: a, data: d};
      @(posedge Clk_100);
      mmio_req <= '0;
   endtask

   // Response is due exactly one cycle after the request
   task automatic mmio_read(input csr_addr_e a, output logic [63:0] d);
      @(posedge Clk_100);
      mmio_req <= '{valid: 1'b1, write: 1'b0, addr: a, data: 64'h0};
      @(posedge Clk_100);
      mmio_req <= '0;
      @(negedge Clk_100);
      if (!mmio_rsp.valid) fail_run("MMIO read got no response one cycle after the request");
      d = mmio_rsp.data;
   endtask

   // -------------------------------------------------------------------------
   // Bus monitor, mid-cycle while requests and credits are stable
   // -------------------------------------------------------------------------
   always @(negedge Clk_100) begin
      int a;
      if (reset) begin
         granted  = 0;
         consumed = 0;
      end else begin
         if (mem_req.valid) begin
            // Only credits granted before this cycle can be spent
            if (granted <= consumed) fail_run("Request sent while the DUT held no credit");
            consumed = consumed + 1;
            a = int'(mem_req.addr);
            if (mem_req.write) begin
               wr_hits[a]  = wr_hits.exists(a) ? wr_hits[a] + 1 : 1;
               wr_lines[a] = mem_req.data;
            end else begin
               rd_hits[a] = rd_hits.exists(a) ? rd_hits[a] + 1 : 1;
            end
         end
         if (credit_return) begin
            granted = granted + 1;
         end
      end
   end

   // -------------------------------------------------------------------------
   // Tests
   // -------------------------------------------------------------------------
   task automatic register_test();
      logic [63:0] word;
      mmio_write(CSR_SCRATCH, 64'h0123_4567_89ab_cdef);
      mmio_read(CSR_SCRATCH, word);
      check("SCRATCH", word, 64'h0123_4567_89ab_cdef);
      mmio_write(CSR_CFG, 64'(M_READ));
      mmio_write(CSR_SRC_ADDR, 64'h0040);
      mmio_write(CSR_NUM_LINES, 64'h0);
      mmio_read(CSR_CFG, word);
      check("CFG", word, 64'(M_READ));
      mmio_read(CSR_SRC_ADDR, word);
      check("SRC_ADDR", word, 64'h0040);
      // Zero line READ run, setup locked while go is set
      mmio_write(CSR_CTL, 64'h1);
      mmio_write(CSR_CFG, 64'(M_TRPUT));
      mmio_write(CSR_NUM_LINES, 64'd99);
      mmio_write(CSR_SCRATCH, 64'hfeed);
      mmio_read(CSR_CFG, word);
      check("CFG locked", word, 64'(M_READ));
      mmio_read(CSR_NUM_LINES, word);
      check("NUM_LINES locked", word, 64'h0);
      mmio_read(CSR_SCRATCH, word);
      check("SCRATCH while go", word, 64'hfeed);
      mmio_write(CSR_CTL, 64'h0);
      // Hole in the register map
      mmio_read(csr_addr_e'(4'hf), word);
      check("unused register", word, 64'h0);
   endtask

   task automatic run_test(input test_t t);
      logic [63:0]       word;
      logic [63:0]       clocks;
      logic [63:0]       src_line;
      logic [ADDR_W-1:0] src_a;
      expect_t           e;
      engine_state_e     st;
      int                n;
      int                a;
      n = int'(t.lines);
      e = expected_result(t.mode, n, 0, '0);
      rd_hits.delete();
      wr_hits.delete();
      wr_lines.delete();
      $display("Start %s, %0d lines, src %h, dst %h", t.mode.name(), n, t.src, t.dst);
      mmio_write(CSR_CFG, 64'(t.mode));
      mmio_write(CSR_SRC_ADDR, 64'(t.src));
      mmio_write(CSR_DST_ADDR, 64'(t.dst));
      mmio_write(CSR_NUM_LINES, 64'(t.lines));
      mmio_write(CSR_CTL, 64'h1);
      // Poll status until done, the watchdog bounds this
      word = '0;
      while (!word[0]) mmio_read(CSR_STATUS, word);
      st = dut_i.test_engine_i.state;
      $display("Done %s, engine in %s", t.mode.name(), st.name());
      check("engine state", 64'(st), 64'(ST_FINISHED));
      mmio_read(CSR_NUM_READS, word);
      check("NUM_READS", word, 64'(e.reads));
      mmio_read(CSR_NUM_WRITES, word);
      check("NUM_WRITES", word, 64'(e.writes));
      mmio_read(CSR_NUM_CLOCKS, clocks);
      if (clocks < 64'(e.reads + e.writes)) fail_run("NUM_CLOCKS is below the request count");
      mmio_read(CSR_NUM_CLOCKS, word);
      check("NUM_CLOCKS frozen", word, clocks);
      check("read addresses", 64'(rd_hits.size()), 64'(e.reads));
      check("write addresses", 64'(wr_hits.size()), 64'(e.writes));
      for (int i = 0; i < n; i++) begin
         a = int'(t.src) + i;
         check("read hits", 64'(rd_hits.exists(a) ? rd_hits[a] : 0), 64'(e.reads != 0));
         if (t.mode != M_READ) begin
            src_a    = ADDR_W'(a);
            src_line = (t.mode == M_LPBK1) ? mem_model_i.mem[src_a] : '0;
            e = expected_result(t.mode, n, i, src_line);
            a = int'(t.dst) + i;
            check("write hits", 64'(wr_hits.exists(a) ? wr_hits[a] : 0), 64'h1);
            check("dst line", wr_lines[a], e.line);
         end
      end
      // Dropping go clears status and counters
      mmio_write(CSR_CTL, 64'h0);
      mmio_read(CSR_STATUS, word);
      check("STATUS after restart", word, 64'h0);
      mmio_read(CSR_NUM_READS, word);
      check("NUM_READS after restart", word, 64'h0);
      mmio_read(CSR_NUM_WRITES, word);
      check("NUM_WRITES after restart", word, 64'h0);
      mmio_read(CSR_NUM_CLOCKS, word);
      check("NUM_CLOCKS after restart", word, 64'h0);
   endtask

   initial begin
      test_t   t;
      expect_t e;
      int      total;
      reset    <= 1'b1;
      mmio_req <= '0;
      total = 0;
      repeat (10) @(posedge Clk_100);
      reset <= 1'b0;
      register_test();
      for (int k = 0; k < NUM_TESTS; k++) begin
         t = test_entry(k);
         run_test(t);
         e = expected_result(t.mode, int'(t.lines), 0, '0);
         total = total + int'(e.reads) + int'(e.writes);
      end
      if (consumed == total) begin
         $display("TESTBENCH PASSED");
         $finish;
      end else begin
         check("total requests", 64'(consumed), 64'(total));
      end
   end

   // Watchdog, sized from the line counts of the table
   initial begin
      longint limit;
      test_t  t;
      limit = CYCLES_PER_TEST;
      for (int k = 0; k < NUM_TESTS; k++) begin
         t = test_entry(k);
         limit = limit + CYCLES_PER_TEST + CYCLES_PER_LINE * longint'(t.lines);
      end
      #(limit * CLK_PERIOD);
      fail_run($sformatf("Timeout after %0d ns, a test never completed", limit * CLK_PERIOD));
   end

endmodule

`default_nettype wire

// ==== verilog/nlb_csr_decode.sv ====
// ---------------------------------------------------------------------------
// MMIO register file. Reads answer exactly one cycle after the request.
// Test mode sits in CSR_CFG[1:0] and go in CSR_CTL[0]. Only CSR_CTL and
// CSR_SCRATCH accept writes while go is set.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module nlb_csr_decode (
   input  logic               Clk_100,
   input  logic               reset,
   input  nlb_pkg::mmio_req_t mmio_req,
   output nlb_pkg::mmio_rsp_t mmio_rsp,
   input  nlb_pkg::test_stat_t stat,
   output nlb_pkg::test_cfg_t cfg
);

   import nlb_pkg::*;

   // Host visible registers
   logic [63:0]        scratch;
   logic [ADDR_W-1:0]  src_addr;
   logic [ADDR_W-1:0]  dst_addr;
   logic [COUNT_W-1:0] num_lines;
   logic               ctl_go;
   test_mode_e         cfg_mode;

   // Read path
   logic               rsp_valid;
   logic [63:0]        rsp_data;
   logic [63:0]        rd_word;
   logic               wr_en;

   assign wr_en = mmio_req.valid && mmio_req.write;

   // -------------------------------------------------------------------------
   // Register writes
   // -------------------------------------------------------------------------
   always_ff @(posedge Clk_100) begin
      if (reset) begin
         scratch   <= '0;
         src_addr  <= '0;
         dst_addr  <= '0;
         num_lines <= '0;
         ctl_go    <= 1'b0;
         cfg_mode  <= M_LPBK1;
      end else if (wr_en) begin
         case (mmio_req.addr)
            CSR_SCRATCH: scratch <= mmio_req.data;
            // Clearing go is the restart path for the whole test
            CSR_CTL:     ctl_go  <= mmio_req.data[0];
            // Test setup is frozen while a test runs
            CSR_SRC_ADDR: begin
               if (!ctl_go) src_addr <= mmio_req.data[ADDR_W-1:0];
            end
            CSR_DST_ADDR: begin
               if (!ctl_go) dst_addr <= mmio_req.data[ADDR_W-1:0];
            end
            CSR_NUM_LINES: begin
               if (!ctl_go) num_lines <= mmio_req.data[COUNT_W-1:0];
            end
            CSR_CFG: begin
               if (!ctl_go) cfg_mode <= test_mode_e'(mmio_req.data[1:0]);
            end
            default: ;
         endcase
      end
   end

   // -------------------------------------------------------------------------
   // Read mux
   // -------------------------------------------------------------------------
   always_comb begin
      case (mmio_req.addr)
         CSR_SCRATCH:    rd_word = scratch;
         CSR_SRC_ADDR:   rd_word = 64'(src_addr);
         CSR_DST_ADDR:   rd_word = 64'(dst_addr);
         CSR_NUM_LINES:  rd_word = 64'(num_lines);
         CSR_CTL:        rd_word = 64'(ctl_go);
         CSR_CFG:        rd_word = 64'(cfg_mode);
         CSR_STATUS:     rd_word = 64'(stat.done);
         CSR_NUM_READS:  rd_word = 64'(stat.num_reads);
         CSR_NUM_WRITES: rd_word = 64'(stat.num_writes);
         CSR_NUM_CLOCKS: rd_word = 64'(stat.num_clocks);
         // Holes in the map read as zero
         default:        rd_word = '0;
      endcase
   end

   // Response strobe
   always_ff @(posedge Clk_100) begin
      if (reset) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= mmio_req.valid && !mmio_req.write;
      end
   end

   always_ff @(posedge Clk_100) begin
      rsp_data <= rd_word;
   end

   assign mmio_rsp = '{valid: rsp_valid, data: rsp_data};

   assign cfg = '{go:        ctl_go,
                  mode:      cfg_mode,
                  src:       src_addr,
                  dst:       dst_addr,
                  num_lines: num_lines};

endmodule

`default_nettype wire

// ==== verilog/nlb_lpbk_buffer.sv ====
// ---------------------------------------------------------------------------
// LPBK1 write-back FIFO of tag and line. The caller never pushes when
// full or pops when empty. clear drops all entries in one cycle.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module nlb_lpbk_buffer (
   input  logic                          Clk_100,
   input  logic                          reset,
   input  logic                          clear,
   input  logic                          push,
   input  logic [nlb_pkg::ADDR_W-1:0]    push_tag,
   input  logic [nlb_pkg::LINE_W-1:0]    push_data,
   input  logic                          pop,
   output logic [nlb_pkg::ADDR_W-1:0]    head_tag,
   output logic [nlb_pkg::LINE_W-1:0]    head_data,
   output logic                          empty,
   output logic [nlb_pkg::LPBK_CNT_W-1:0] count
);

   import nlb_pkg::*;

   logic [ADDR_W-1:0]     tag_mem  [LPBK_DEPTH];
   logic [LINE_W-1:0]     data_mem [LPBK_DEPTH];
   logic [LPBK_PTR_W-1:0] wr_ptr;
   logic [LPBK_PTR_W-1:0] rd_ptr;

   // Storage
   always_ff @(posedge Clk_100) begin
      if (push) begin
         tag_mem[wr_ptr]  <= push_tag;
         data_mem[wr_ptr] <= push_data;
      end
   end

   // Pointers wrap naturally at the power of two depth
   always_ff @(posedge Clk_100) begin
      if (reset || clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         count <= count + LPBK_CNT_W'(push) - LPBK_CNT_W'(pop);
      end
   end

   assign head_tag  = tag_mem[rd_ptr];
   assign head_data = data_mem[rd_ptr];
   assign empty     = (count == '0);

endmodule

`default_nettype wire

// ==== verilog/nlb_pkg.sv ====
// ---------------------------------------------------------------------------
// Shared sizes, encodings and bus structs of the loopback tester.
// LPBK_DEPTH must be a power of two. Lines are 64 bits and addresses
// count lines, not bytes.
// ---------------------------------------------------------------------------
`default_nettype none

package nlb_pkg;

   // Datapath and counter widths
   localparam int LINE_W  = 64;
   localparam int ADDR_W  = 16;
   localparam int COUNT_W = 32;

   // Memory side flow control
   localparam int MEM_CREDITS = 4;
   localparam int CREDIT_W    = $clog2(MEM_CREDITS + 1);

   // Loopback write-back FIFO
   localparam int LPBK_DEPTH = 4;
   localparam int LPBK_PTR_W = $clog2(LPBK_DEPTH);
   localparam int LPBK_CNT_W = $clog2(LPBK_DEPTH + 1);

   // Upper half of every WRITE / TRPUT line
   localparam logic [31:0] WR_PATTERN = 32'hc0de_5a5a;

   // -------------------------------------------------------------------------
   // Encodings
   // -------------------------------------------------------------------------
   // MMIO word index, one 64 bit register per index
   typedef enum logic [3:0] {
      CSR_SCRATCH    = 4'd0,
      CSR_SRC_ADDR   = 4'd1,
      CSR_DST_ADDR   = 4'd2,
      CSR_NUM_LINES  = 4'd3,
      CSR_CTL        = 4'd4,
      CSR_CFG        = 4'd5,
      CSR_STATUS     = 4'd6,
      CSR_NUM_READS  = 4'd7,
      CSR_NUM_WRITES = 4'd8,
      CSR_NUM_CLOCKS = 4'd9
   } csr_addr_e;

   typedef enum logic [1:0] {
      M_LPBK1 = 2'd0,
      M_READ  = 2'd1,
      M_WRITE = 2'd2,
      M_TRPUT = 2'd3
   } test_mode_e;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ISSUE,
      ST_FINISHED
   } engine_state_e;

   // -------------------------------------------------------------------------
   // Bus structs
   // -------------------------------------------------------------------------
   typedef struct packed {
      logic        valid;
      logic        write;
      csr_addr_e   addr;
      logic [63:0] data;
   } mmio_req_t;

   typedef struct packed {
      logic        valid;
      logic [63:0] data;
   } mmio_rsp_t;

   // Tag is the line offset within the test
   typedef struct packed {
      logic              valid;
      logic              write;
      logic [ADDR_W-1:0] addr;
      logic [ADDR_W-1:0] tag;
      logic [LINE_W-1:0] data;
   } mem_req_t;

   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] tag;
      logic [LINE_W-1:0] data;
   } mem_rsp_t;

   typedef struct packed {
      logic               go;
      test_mode_e         mode;
      logic [ADDR_W-1:0]  src;
      logic [ADDR_W-1:0]  dst;
      logic [COUNT_W-1:0] num_lines;
   } test_cfg_t;

   typedef struct packed {
      logic               done;
      logic [COUNT_W-1:0] num_reads;
      logic [COUNT_W-1:0] num_writes;
      logic [COUNT_W-1:0] num_clocks;
   } test_stat_t;

endpackage

`default_nettype wire

// ==== verilog/nlb_result.sv ====
// ---------------------------------------------------------------------------
// Test counters and completion. done rises a cycle after issuing ends
// with every read answered, and holds until go falls.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module nlb_result (
   input  logic                Clk_100,
   input  logic                reset,
   input  nlb_pkg::test_cfg_t  cfg,
   input  nlb_pkg::mem_req_t   mem_req,
   input  nlb_pkg::mem_rsp_t   mem_rsp,
   input  logic                issue_done,
   output nlb_pkg::test_stat_t stat
);

   import nlb_pkg::*;

   logic [COUNT_W-1:0] rd_cnt;
   logic [COUNT_W-1:0] wr_cnt;
   logic [COUNT_W-1:0] rsp_cnt;
   logic [COUNT_W-1:0] clk_cnt;
   logic               done;

   // -------------------------------------------------------------------------
   // Counters
   // -------------------------------------------------------------------------
   always_ff @(posedge Clk_100) begin
      if (reset || !cfg.go) begin
         rd_cnt  <= '0;
         wr_cnt  <= '0;
         rsp_cnt <= '0;
         clk_cnt <= '0;
         done    <= 1'b0;
      end else begin
         if (mem_req.valid && !mem_req.write) begin
            rd_cnt <= rd_cnt + 1'b1;
         end
         if (mem_req.valid && mem_req.write) begin
            wr_cnt <= wr_cnt + 1'b1;
         end
         if (mem_rsp.valid) begin
            rsp_cnt <= rsp_cnt + 1'b1;
         end
         // Run time freezes once the test is complete
         if (!done) begin
            clk_cnt <= clk_cnt + 1'b1;
         end
         // Sticky until the host drops go
         if (issue_done && rsp_cnt == rd_cnt) begin
            done <= 1'b1;
         end
      end
   end

   assign stat = '{done:       done,
                   num_reads:  rd_cnt,
                   num_writes: wr_cnt,
                   num_clocks: clk_cnt};

endmodule

`default_nettype wire

// ==== verilog/nlb_test_engine.sv ====
// ---------------------------------------------------------------------------
// Request sequencer for all four test modes. At most one request per cycle,
// each one spends a credit. Credits start at zero and arrive on
// credit_return. num_lines must fit the ADDR_W bit line space.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module nlb_test_engine (
   input  logic                Clk_100,
   input  logic                reset,
   input  nlb_pkg::test_cfg_t  cfg,
   output nlb_pkg::mem_req_t   mem_req,
   input  logic                credit_return,
   input  nlb_pkg::mem_rsp_t   mem_rsp,
   output logic                issue_done
);

   import nlb_pkg::*;

   engine_state_e      state;
   logic [CREDIT_W-1:0] credits;
   logic [CREDIT_W-1:0] rd_out;
   logic [CREDIT_W:0]  lpbk_used;
   logic [COUNT_W-1:0] rd_idx;
   logic [COUNT_W-1:0] wr_idx;
   logic               alt_wr;
   logic               lpbk;
   logic               rd_left;
   logic               wr_left;
   logic               all_sent;
   logic               sel_rd;
   logic               sel_wr;
   logic [ADDR_W-1:0]  wr_tag;

   // Loopback buffer
   logic               buf_push;
   logic               buf_empty;
   logic [ADDR_W-1:0]  head_tag;
   logic [LINE_W-1:0]  head_data;
   logic [LPBK_CNT_W-1:0] buf_count;

   assign lpbk    = (cfg.mode == M_LPBK1);
   assign rd_left = (rd_idx != cfg.num_lines);
   assign wr_left = (wr_idx != cfg.num_lines);

   // Reads in flight plus parked write-backs must fit the buffer
   assign lpbk_used = {1'b0, rd_out} + (CREDIT_W + 1)'(buf_count);

   // -------------------------------------------------------------------------
   // Request selection
   // -------------------------------------------------------------------------
   always_comb begin
      sel_rd = 1'b0;
      sel_wr = 1'b0;
      if (state == ST_ISSUE && credits != '0) begin
         case (cfg.mode)
            M_LPBK1: begin
               // Draining write-backs first keeps the buffer moving
               sel_wr = !buf_empty;
               sel_rd = buf_empty && rd_left &&
                        (lpbk_used < (CREDIT_W + 1)'(LPBK_DEPTH));
            end
            M_READ:  sel_rd = rd_left;
            M_WRITE: sel_wr = wr_left;
            M_TRPUT: begin
               // Ping-pong while both streams remain
               sel_wr = wr_left && (alt_wr || !rd_left);
               sel_rd = rd_left && !sel_wr;
            end
         endcase
      end
   end

   // Every request of the mode has left
   always_comb begin
      case (cfg.mode)
         M_READ:  all_sent = !rd_left;
         M_WRITE: all_sent = !wr_left;
         default: all_sent = !rd_left && !wr_left;
      endcase
   end

   assign wr_tag = lpbk ? head_tag : wr_idx[ADDR_W-1:0];

   always_comb begin
      mem_req       = '0;
      mem_req.valid = sel_rd || sel_wr;
      mem_req.write = sel_wr;
      mem_req.tag   = sel_wr ? wr_tag : rd_idx[ADDR_W-1:0];
      mem_req.addr  = sel_wr ? cfg.dst + wr_tag : cfg.src + rd_idx[ADDR_W-1:0];
      if (sel_wr) begin
         // LPBK1 copies, WRITE and TRPUT send pattern plus line index
         mem_req.data = lpbk ? head_data : {WR_PATTERN, wr_idx};
      end
   end

   // -------------------------------------------------------------------------
   // FSM
   // -------------------------------------------------------------------------
   always_ff @(posedge Clk_100) begin
      if (reset || !cfg.go) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE:  state <= ST_ISSUE;
            ST_ISSUE: begin
               if (all_sent) state <= ST_FINISHED;
            end
            default:  state <= ST_FINISHED;
         endcase
      end
   end

   assign issue_done = (state == ST_FINISHED);

   // Credits belong to the memory side and survive a restart
   always_ff @(posedge Clk_100) begin
      if (reset) begin
         credits <= '0;
      end else begin
         credits <= credits + CREDIT_W'(credit_return) - CREDIT_W'(mem_req.valid);
      end
   end

   // Per-test progress, cleared when go drops
   always_ff @(posedge Clk_100) begin
      if (reset || !cfg.go) begin
         rd_idx <= '0;
         wr_idx <= '0;
         rd_out <= '0;
         alt_wr <= 1'b0;
      end else begin
         if (sel_rd) rd_idx <= rd_idx + 1'b1;
         if (sel_wr) wr_idx <= wr_idx + 1'b1;
         rd_out <= rd_out + CREDIT_W'(sel_rd) - CREDIT_W'(mem_rsp.valid);
         if (mem_req.valid) alt_wr <= !alt_wr;
      end
   end

   // Read returns only matter to LPBK1
   assign buf_push = mem_rsp.valid && lpbk && cfg.go;

   nlb_lpbk_buffer lpbk_buf_i (
      .Clk_100   (Clk_100),
      .reset     (reset),
      .clear     (!cfg.go),
      .push      (buf_push),
      .push_tag  (mem_rsp.tag),
      .push_data (mem_rsp.data),
      .pop       (sel_wr && lpbk),
      .head_tag  (head_tag),
      .head_data (head_data),
      .empty     (buf_empty),
      .count     (buf_count)
   );

endmodule

`default_nettype wire

// ==== verilog/nlb_top.sv ====
// ---------------------------------------------------------------------------
// Loopback tester top. MMIO in, credit-based line requests out.
// credit_return adds one credit per pulse and read responses are
// never back-pressured.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module nlb_top (
   input  logic               Clk_100,
   input  logic               reset,
   input  nlb_pkg::mmio_req_t mmio_req,
   output nlb_pkg::mmio_rsp_t mmio_rsp,
   output nlb_pkg::mem_req_t  mem_req,
   input  logic               credit_return,
   input  nlb_pkg::mem_rsp_t  mem_rsp
);

   import nlb_pkg::*;

   test_cfg_t  cfg;
   test_stat_t stat;
   logic       issue_done;

   // Decode
   nlb_csr_decode csr_decode_i (
      .Clk_100  (Clk_100),
      .reset    (reset),
      .mmio_req (mmio_req),
      .mmio_rsp (mmio_rsp),
      .stat     (stat),
      .cfg      (cfg)
   );

   // Execute
   nlb_test_engine test_engine_i (
      .Clk_100       (Clk_100),
      .reset         (reset),
      .cfg           (cfg),
      .mem_req       (mem_req),
      .credit_return (credit_return),
      .mem_rsp       (mem_rsp),
      .issue_done    (issue_done)
   );

   // Result
   nlb_result result_i (
      .Clk_100    (Clk_100),
      .reset      (reset),
      .cfg        (cfg),
      .mem_req    (mem_req),
      .mem_rsp    (mem_rsp),
      .issue_done (issue_done),
      .stat       (stat)
   );

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/nlb_pkg.sv
verilog/nlb_lpbk_buffer.sv
verilog/nlb_csr_decode.sv
verilog/nlb_test_engine.sv
verilog/nlb_result.sv
verilog/nlb_top.sv
verif/nlb_mem_model.sv
verif/tb_nlb.sv
